/* dv/conv_tb.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"
// Convolution system testbench
// Loads both memories, runs the engine and checks every output against a model

module conv_tb;

    localparam int N_PE   = `CONV_N_PE;
    localparam int N_POS  = `CONV_N_POS;
    localparam int WDEPTH = `CONV_N_KER * (`CONV_N_PE + 1);
    localparam int FDEPTH = `CONV_N_POS * `CONV_N_PE;
    localparam int ODEPTH = `CONV_N_KER * `CONV_N_POS;
    localparam int WAW    = `CONV_WMEM_AW;
    localparam int FAW    = `CONV_FIB_AW;
    localparam int OAW    = `CONV_OMEM_AW;
    // Four runs plus loads, readback and the quiet period with margin
    localparam int LIMIT  = 5000;

    logic           clk;
    logic           rst_n;
    logic           start;
    logic           done;
    logic [WAW-1:0] cpu_wmem_wr_addr;
    logic [31:0]    cpu_wmem_wr_data;
    logic           cpu_wmem_wr_en;
    logic [FAW-1:0] cpu_fib_wr_addr;
    logic [31:0]    cpu_fib_wr_data;
    logic           cpu_fib_wr_en;
    logic [OAW-1:0] cpu_omem_rd_addr;
    logic           cpu_omem_rd_en;
    logic [31:0]    cpu_omem_rd_data;

    // Model copies of both memories
    logic [31:0]    wmem_m [WDEPTH];
    logic [31:0]    fib_m [FDEPTH];

    integer         seed;
    int             cycle_cnt;
    int             done_cnt;
    logic           cmp_vld;
    logic [OAW-1:0] cmp_addr;

    conv_system_top u_dut (
        .clk(clk), .rst_n(rst_n), .start(start), .done(done),
        .cpu_wmem_wr_addr(cpu_wmem_wr_addr), .cpu_wmem_wr_data(cpu_wmem_wr_data),
        .cpu_wmem_wr_en(cpu_wmem_wr_en),
        .cpu_fib_wr_addr(cpu_fib_wr_addr), .cpu_fib_wr_data(cpu_fib_wr_data),
        .cpu_fib_wr_en(cpu_fib_wr_en),
        .cpu_omem_rd_addr(cpu_omem_rd_addr), .cpu_omem_rd_en(cpu_omem_rd_en),
        .cpu_omem_rd_data(cpu_omem_rd_data)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // ====================
    // Reference and checks
    // ====================
    // Bias plus signed byte products over every PE and lane with 32-bit wrap
    function automatic int ref_out(input int k, input int p);
        int                acc;
        logic signed [7:0] wb;
        logic signed [7:0] xb;
        acc = int'(wmem_m[k * (N_PE + 1) + N_PE]);
        for (int pe = 0; pe < N_PE; pe++) begin
            for (int ln = 0; ln < `CONV_LANES; ln++) begin
                wb  = wmem_m[k * (N_PE + 1) + pe][ln * 8 +: 8];
                xb  = fib_m[p * N_PE + pe][ln * 8 +: 8];
                acc = acc + int'(wb) * int'(xb);
            end
        end
        return acc;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Read data lands one cycle after rd_en and is compared mid-cycle
    always @(posedge clk) begin
        cmp_vld  <= cpu_omem_rd_en;
        cmp_addr <= cpu_omem_rd_addr;
    end

    always @(negedge clk) begin
        if (cmp_vld) begin
            check($sformatf("cpu_omem_rd_data[%0d]", cmp_addr), cpu_omem_rd_data,
                  ref_out(int'(cmp_addr) / N_POS, int'(cmp_addr) % N_POS));
        end
    end

    // done pulses seen since reset release
    always @(posedge clk) begin
        if (rst_n && done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            $display("=== FAIL ===");
            $fatal(1, "Timeout, the run did not finish within %0d cycles", LIMIT);
        end
    end

    // ====================
    // Host tasks
    // ====================
    task automatic put_wmem(input int addr, input logic [31:0] data);
        @(posedge clk);
        cpu_wmem_wr_addr <= WAW'(addr);
        cpu_wmem_wr_data <= data;
        cpu_wmem_wr_en   <= 1'b1;
        wmem_m[addr] = data;
    endtask

    task automatic put_fib(input int addr, input logic [31:0] data);
        @(posedge clk);
        cpu_fib_wr_addr <= FAW'(addr);
        cpu_fib_wr_data <= data;
        cpu_fib_wr_en   <= 1'b1;
        fib_m[addr] = data;
    endtask

    task automatic end_writes();
        @(posedge clk);
        cpu_wmem_wr_en <= 1'b0;
        cpu_fib_wr_en  <= 1'b0;
    endtask

    // Weights and biases alike are random words
    task automatic fill_weights_random();
        for (int a = 0; a < WDEPTH; a++) begin
            put_wmem(a, $random(seed));
        end
        end_writes();
    endtask

    task automatic fill_inputs_random();
        for (int a = 0; a < FDEPTH; a++) begin
            put_fib(a, $random(seed));
        end
        end_writes();
    endtask

    // All bytes at -128 and biases near the positive limit
    task automatic fill_extreme();
        for (int a = 0; a < WDEPTH; a++) begin
            if (a % (N_PE + 1) == N_PE) begin
                put_wmem(a, 32'h7ffe_0000 + 32'(a));
            end else begin
                put_wmem(a, 32'h8080_8080);
            end
        end
        for (int a = 0; a < FDEPTH; a++) begin
            put_fib(a, 32'h8080_8080);
        end
        end_writes();
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(input int cnt0);
        while (done_cnt == cnt0) begin
            @(negedge clk);
        end
    endtask

    task automatic run_engine();
        int cnt0;
        cnt0 = done_cnt;
        pulse_start();
        wait_done(cnt0);
    endtask

    // Every output address once and a drain for the last compare
    task automatic read_all();
        for (int a = 0; a < ODEPTH; a++) begin
            @(posedge clk);
            cpu_omem_rd_addr <= OAW'(a);
            cpu_omem_rd_en   <= 1'b1;
        end
        @(posedge clk);
        cpu_omem_rd_en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        int cnt0;
        seed             = 32'h4f4dfaa8;
        clk              = 1'b0;
        rst_n            = 1'b0;
        start            = 1'b0;
        cpu_wmem_wr_addr = '0;
        cpu_wmem_wr_data = '0;
        cpu_wmem_wr_en   = 1'b0;
        cpu_fib_wr_addr  = '0;
        cpu_fib_wr_data  = '0;
        cpu_fib_wr_en    = 1'b0;
        cpu_omem_rd_addr = '0;
        cpu_omem_rd_en   = 1'b0;
        cycle_cnt        = 0;
        done_cnt         = 0;
        cmp_vld          = 1'b0;
        cmp_addr         = '0;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // done quiet with no start
        repeat (20) begin
            @(negedge clk);
            check("done", 32'(done), 32'h0);
        end

        // Random operands
        fill_weights_random();
        fill_inputs_random();
        run_engine();
        read_all();

        // Extreme bytes with wrapping bias sums
        fill_extreme();
        run_engine();
        read_all();

        // New weights without a reset in between
        fill_weights_random();
        fill_inputs_random();
        run_engine();
        read_all();

        // Second start mid-run is dropped
        fill_weights_random();
        cnt0 = done_cnt;
        pulse_start();
        repeat (100) @(posedge clk);
        pulse_start();
        wait_done(cnt0);
        repeat (500) @(posedge clk);
        check("done_cnt", 32'(done_cnt - cnt0), 32'h1);
        read_all();

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* list.f */
+incdir+src
src/conv_pkg.sv
src/conv_load_if.sv
src/conv_memory.sv
src/weight_buffer.sv
src/input_buffer.sv
src/pe_array.sv
src/conv_controller.sv
src/conv_system_top.sv
dv/conv_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the convolution testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module conv_tb -f list.f -o conv_sim \
    && ./obj_dir/conv_sim \
    || exit 1

/* src/conv_consts.svh */
// Size constants for the convolution engine
// Array shape, kernel and position counts, and memory address widths
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// ====================
// Memory layout
//   weight memory  kernel k, PE word pe at k*(N_PE+1)+pe, bias at k*(N_PE+1)+N_PE
//   input memory   position p, PE word pe at p*N_PE+pe
//   output memory  result (k, p) at k*N_POS+p
// ====================

// Processing elements, one weight word each per kernel
`define CONV_N_PE    4
// Output positions computed in parallel
`define CONV_N_WIN   2
// Int8 lanes per 32-bit word
`define CONV_LANES   4
`define CONV_N_KER   4
// Must be a multiple of CONV_N_WIN
`define CONV_N_POS   8

// Address widths, 20 / 32 / 32 words deep
`define CONV_WMEM_AW 5
`define CONV_FIB_AW  5
`define CONV_OMEM_AW 5

`endif

/* src/conv_controller.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"
// Convolution controller
// Sequences weight loads, window loads, compute and result write-back

module conv_controller (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    output logic                           done,
    output logic [`CONV_WMEM_AW-1:0]       wmem_rd_addr,
    output logic                           wmem_rd_en,
    input  conv_pkg::conv_word_u           wmem_rd_data,
    output logic [`CONV_FIB_AW-1:0]        fib_rd_addr,
    output logic                           fib_rd_en,
    input  conv_pkg::conv_word_u           fib_rd_data,
    output logic [`CONV_OMEM_AW-1:0]       omem_wr_addr,
    output conv_pkg::conv_word_u           omem_wr_data,
    output logic                           omem_wr_en,
    wload_if.ctrl                          wload,
    iload_if.ctrl                          iload,
    output logic                           calc_valid,
    output logic [$clog2(`CONV_N_WIN)-1:0] res_idx,
    input  logic                           res_valid,
    input  conv_pkg::acc_t                 res_data
);
    localparam int N_PE     = `CONV_N_PE;
    localparam int N_WIN    = `CONV_N_WIN;
    localparam int N_KER    = `CONV_N_KER;
    localparam int N_POS    = `CONV_N_POS;
    localparam int N_GRP    = N_POS / N_WIN;
    // Input words per group
    localparam int N_IWORDS = N_PE * N_WIN;
    localparam int CNT_W    = $clog2(N_IWORDS > N_PE + 1 ? N_IWORDS : N_PE + 1);
    localparam int KW       = $clog2(N_KER);
    localparam int GW       = $clog2(N_GRP);
    localparam int PIW      = $clog2(N_PE);
    localparam int WIW      = $clog2(N_WIN);
    localparam int WAW      = `CONV_WMEM_AW;
    localparam int FAW      = `CONV_FIB_AW;
    localparam int OAW      = `CONV_OMEM_AW;

    typedef enum logic [2:0] {
        S_IDLE, S_WRD, S_IRD, S_DRAIN, S_CALC, S_WAIT, S_WR, S_DONE
    } state_t;

    state_t           state;
    logic [KW-1:0]    k_cnt;
    logic [GW-1:0]    grp_cnt;
    // Word counter, reused as the window counter during write-back
    logic [CNT_W-1:0] word_cnt;
    // Read index delayed to match memory latency
    logic [CNT_W-1:0] word_q;
    logic             wvld_q;
    logic             ivld_q;
    logic             last_k;
    logic             last_grp;

    assign last_k   = (k_cnt == KW'(N_KER - 1));
    assign last_grp = (grp_cnt == GW'(N_GRP - 1));

    // ====================
    // FSM and counters
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            k_cnt    <= '0;
            grp_cnt  <= '0;
            word_cnt <= '0;
            word_q   <= '0;
            wvld_q   <= 1'b0;
            ivld_q   <= 1'b0;
        end else begin
            wvld_q <= (state == S_WRD);
            ivld_q <= (state == S_IRD);
            word_q <= word_cnt;
            case (state)
                // Start only taken here
                S_IDLE: if (start) begin
                    k_cnt    <= '0;
                    grp_cnt  <= '0;
                    word_cnt <= '0;
                    state    <= S_WRD;
                end
                // N_PE weight words then the bias
                S_WRD: if (word_cnt == CNT_W'(N_PE)) begin
                    word_cnt <= '0;
                    state    <= S_IRD;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
                S_IRD: if (word_cnt == CNT_W'(N_IWORDS - 1)) begin
                    word_cnt <= '0;
                    state    <= S_DRAIN;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
                // Last input word lands in the buffer
                S_DRAIN: state <= S_CALC;
                S_CALC:  state <= S_WAIT;
                S_WAIT:  if (res_valid) state <= S_WR;
                // One result per cycle, then next group or kernel
                S_WR: if (word_cnt == CNT_W'(N_WIN - 1)) begin
                    word_cnt <= '0;
                    if (!last_grp) begin
                        grp_cnt <= grp_cnt + 1'b1;
                        state   <= S_IRD;
                    end else if (!last_k) begin
                        grp_cnt <= '0;
                        k_cnt   <= k_cnt + 1'b1;
                        state   <= S_WRD;
                    end else begin
                        state <= S_DONE;
                    end
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
                S_DONE:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // ====================
    // Memory reads
    // ====================
    assign wmem_rd_en   = (state == S_WRD);
    assign wmem_rd_addr = WAW'(k_cnt * (N_PE + 1) + word_cnt);
    // Group base plus word, positions of a group are contiguous
    assign fib_rd_en    = (state == S_IRD);
    assign fib_rd_addr  = FAW'(grp_cnt * N_IWORDS + word_cnt);

    // Steer returned words with the delayed index
    assign wload.load_en = wvld_q && (word_q < CNT_W'(N_PE));
    assign wload.bias_en = wvld_q && (word_q == CNT_W'(N_PE));
    assign wload.pe_idx  = PIW'(word_q);
    assign wload.data    = wmem_rd_data;

    assign iload.load_en = ivld_q;
    assign iload.pe_idx  = PIW'(word_q % N_PE);
    assign iload.win_idx = WIW'(word_q / N_PE);
    assign iload.data    = fib_rd_data;

    // ====================
    // Compute and write-back
    // ====================
    assign calc_valid       = (state == S_CALC);
    assign res_idx          = WIW'(word_cnt);
    assign omem_wr_en       = (state == S_WR);
    assign omem_wr_addr     = OAW'(k_cnt * N_POS + grp_cnt * N_WIN + word_cnt);
    assign omem_wr_data.word = res_data;
    assign done             = (state == S_DONE);

endmodule

/* src/conv_load_if.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"
// Buffer load interfaces
// Word strobes from the controller into the weight and input buffers

// ====================
// Weight buffer load
// ====================
interface wload_if;
    import conv_pkg::*;

    // PE word strobe
    logic                          load_en;
    logic [$clog2(`CONV_N_PE)-1:0] pe_idx;
    // Bias word strobe
    logic                          bias_en;
    conv_word_u                    data;

    modport ctrl   (output load_en, output pe_idx, output bias_en, output data);
    modport buffer (input load_en, input pe_idx, input bias_en, input data);
endinterface

// ====================
// Input buffer load
// ====================
interface iload_if;
    import conv_pkg::*;

    logic                           load_en;
    logic [$clog2(`CONV_N_PE)-1:0]  pe_idx;
    // Window slot inside the current group
    logic [$clog2(`CONV_N_WIN)-1:0] win_idx;
    conv_word_u                     data;

    modport ctrl   (output load_en, output pe_idx, output win_idx, output data);
    modport buffer (input load_en, input pe_idx, input win_idx, input data);
endinterface

/* src/conv_memory.sv */
`timescale 1ns/1ps
// Word memory
// One write port and one registered read port

module conv_memory #(
    parameter int DEPTH = 32,
    parameter int AW    = 5
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [AW-1:0]        wr_addr,
    input  conv_pkg::conv_word_u wr_data,
    input  logic                 wr_en,
    input  logic [AW-1:0]        rd_addr,
    input  logic                 rd_en,
    output conv_pkg::conv_word_u rd_data
);
    import conv_pkg::*;

    conv_word_u mem [DEPTH];
    conv_word_u rd_q;

    // Write lands at the clock edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data one cycle after rd_en, held until the next read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q <= '0;
        end else if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

    assign rd_data = rd_q;

endmodule

/* src/conv_pkg.sv */
// Convolution engine types
// Word union plus operand and result arrays shared by the datapath
`include "conv_consts.svh"

package conv_pkg;

    // One memory word
    // Weight and input words decode as int8 lanes, lane 0 in the low byte
    // Bias and result words decode as one signed 32-bit value
    typedef union packed {
        logic [`CONV_LANES-1:0][7:0] lanes;
        logic signed [31:0]          word;
    } conv_word_u;

    // One kernel's PE weights
    typedef conv_word_u [`CONV_N_PE-1:0] pe_words_t;

    // Inputs of every window for one compute
    typedef conv_word_u [`CONV_N_WIN-1:0][`CONV_N_PE-1:0] win_words_t;

    // Accumulator and output value, wraps at 32 bits
    typedef logic signed [31:0] acc_t;

endpackage

/* src/conv_system_top.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"
// Convolution system top
// Memories, controller, operand buffers and PE array

module conv_system_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    output logic                     done,
    // Host weight memory load
    input  logic [`CONV_WMEM_AW-1:0] cpu_wmem_wr_addr,
    input  logic [31:0]              cpu_wmem_wr_data,
    input  logic                     cpu_wmem_wr_en,
    // Host input memory load
    input  logic [`CONV_FIB_AW-1:0]  cpu_fib_wr_addr,
    input  logic [31:0]              cpu_fib_wr_data,
    input  logic                     cpu_fib_wr_en,
    // Host result readback
    input  logic [`CONV_OMEM_AW-1:0] cpu_omem_rd_addr,
    input  logic                     cpu_omem_rd_en,
    output logic [31:0]              cpu_omem_rd_data
);
    import conv_pkg::*;

    // ====================
    // Internal wires
    // ====================
    logic [`CONV_WMEM_AW-1:0]       wmem_rd_addr;
    logic                           wmem_rd_en;
    conv_word_u                     wmem_rd_data;
    logic [`CONV_FIB_AW-1:0]        fib_rd_addr;
    logic                           fib_rd_en;
    conv_word_u                     fib_rd_data;
    logic [`CONV_OMEM_AW-1:0]       omem_wr_addr;
    conv_word_u                     omem_wr_data;
    logic                           omem_wr_en;
    logic                           calc_valid;
    logic                           res_valid;
    logic [$clog2(`CONV_N_WIN)-1:0] res_idx;
    acc_t                           res_data;
    pe_words_t                      weights;
    acc_t                           bias;
    win_words_t                     windows;

    wload_if u_wload ();
    iload_if u_iload ();

    // ====================
    // Memories
    // ====================
    conv_memory #(.DEPTH(`CONV_N_KER * (`CONV_N_PE + 1)), .AW(`CONV_WMEM_AW)) u_wmem (
        .clk(clk), .rst_n(rst_n),
        .wr_addr(cpu_wmem_wr_addr), .wr_data(cpu_wmem_wr_data), .wr_en(cpu_wmem_wr_en),
        .rd_addr(wmem_rd_addr), .rd_en(wmem_rd_en), .rd_data(wmem_rd_data)
    );

    conv_memory #(.DEPTH(`CONV_N_POS * `CONV_N_PE), .AW(`CONV_FIB_AW)) u_fib (
        .clk(clk), .rst_n(rst_n),
        .wr_addr(cpu_fib_wr_addr), .wr_data(cpu_fib_wr_data), .wr_en(cpu_fib_wr_en),
        .rd_addr(fib_rd_addr), .rd_en(fib_rd_en), .rd_data(fib_rd_data)
    );

    // Engine writes, host reads
    conv_memory #(.DEPTH(`CONV_N_KER * `CONV_N_POS), .AW(`CONV_OMEM_AW)) u_omem (
        .clk(clk), .rst_n(rst_n),
        .wr_addr(omem_wr_addr), .wr_data(omem_wr_data), .wr_en(omem_wr_en),
        .rd_addr(cpu_omem_rd_addr), .rd_en(cpu_omem_rd_en), .rd_data(cpu_omem_rd_data)
    );

    // ====================
    // Engine
    // ====================
    conv_controller u_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start), .done(done),
        .wmem_rd_addr(wmem_rd_addr), .wmem_rd_en(wmem_rd_en), .wmem_rd_data(wmem_rd_data),
        .fib_rd_addr(fib_rd_addr), .fib_rd_en(fib_rd_en), .fib_rd_data(fib_rd_data),
        .omem_wr_addr(omem_wr_addr), .omem_wr_data(omem_wr_data), .omem_wr_en(omem_wr_en),
        .wload(u_wload.ctrl), .iload(u_iload.ctrl),
        .calc_valid(calc_valid), .res_idx(res_idx),
        .res_valid(res_valid), .res_data(res_data)
    );

    weight_buffer u_wbuf (
        .clk(clk), .rst_n(rst_n), .load(u_wload.buffer), .weights(weights), .bias(bias)
    );

    input_buffer u_ibuf (
        .clk(clk), .rst_n(rst_n), .load(u_iload.buffer), .windows(windows)
    );

    pe_array u_pe (
        .clk(clk), .rst_n(rst_n), .calc_valid(calc_valid),
        .weights(weights), .bias(bias), .windows(windows),
        .res_valid(res_valid), .res_idx(res_idx), .res_data(res_data)
    );

endmodule

/* src/input_buffer.sv */
`timescale 1ns/1ps
// Input buffer
// Holds the input words of every window for one compute

module input_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    iload_if.buffer              load,
    output conv_pkg::win_words_t windows
);
    import conv_pkg::*;

    win_words_t win_q;

    // ====================
    // Load port
    // ====================
    // Each word lands at its window slot and PE
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_q <= '0;
        end else if (load.load_en) begin
            win_q[load.win_idx][load.pe_idx] <= load.data;
        end
    end

    // All windows feed the PE array in parallel
    assign windows = win_q;

endmodule

/* src/pe_array.sv */
`timescale 1ns/1ps
`include "conv_consts.svh"
// PE array
// Two-stage int8 multiply and reduce over all windows, results held

module pe_array (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           calc_valid,
    input  conv_pkg::pe_words_t            weights,
    input  conv_pkg::acc_t                 bias,
    input  conv_pkg::win_words_t           windows,
    output logic                           res_valid,
    input  logic [$clog2(`CONV_N_WIN)-1:0] res_idx,
    output conv_pkg::acc_t                 res_data
);
    import conv_pkg::*;

    localparam int N_PE  = `CONV_N_PE;
    localparam int N_WIN = `CONV_N_WIN;
    localparam int LANES = `CONV_LANES;

    // Lane products per window, PE and lane
    logic signed [15:0] prod_q [N_WIN][N_PE][LANES];
    acc_t               bias_q;
    logic               prod_vld_q;
    acc_t               sum_c [N_WIN];
    acc_t               res_q [N_WIN];
    logic               res_vld_q;

    // ====================
    // Stage 1
    // ====================
    // Signed lane products, bias captured alongside
    always_ff @(posedge clk) begin
        if (calc_valid) begin
            bias_q <= bias;
            for (int w = 0; w < N_WIN; w++) begin
                for (int p = 0; p < N_PE; p++) begin
                    for (int l = 0; l < LANES; l++) begin
                        prod_q[w][p][l] <= $signed(weights[p].lanes[l]) *
                                           $signed(windows[w][p].lanes[l]);
                    end
                end
            end
        end
    end

    // ====================
    // Stage 2
    // ====================
    // Bias plus every product of the window, wraps at 32 bits
    always_comb begin
        for (int w = 0; w < N_WIN; w++) begin
            sum_c[w] = bias_q;
            for (int p = 0; p < N_PE; p++) begin
                for (int l = 0; l < LANES; l++) begin
                    sum_c[w] = sum_c[w] + acc_t'(prod_q[w][p][l]);
                end
            end
        end
    end

    // Held until the next compute
    always_ff @(posedge clk) begin
        if (prod_vld_q) begin
            res_q <= sum_c;
        end
    end

    // Valid pipe, res_valid two cycles after calc_valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_vld_q <= 1'b0;
            res_vld_q  <= 1'b0;
        end else begin
            prod_vld_q <= calc_valid;
            res_vld_q  <= prod_vld_q;
        end
    end

    assign res_valid = res_vld_q;
    assign res_data  = res_q[res_idx];

endmodule

/* src/weight_buffer.sv */
`timescale 1ns/1ps
// Weight buffer
// Holds the current kernel's PE weight words and its bias

module weight_buffer (
    input  logic                clk,
    input  logic                rst_n,
    wload_if.buffer             load,
    output conv_pkg::pe_words_t weights,
    output conv_pkg::acc_t      bias
);
    import conv_pkg::*;

    pe_words_t  w_q;
    conv_word_u bias_q;

    // Entry updates one edge after its strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w_q    <= '0;
            bias_q <= '0;
        end else begin
            if (load.load_en) begin
                w_q[load.pe_idx] <= load.data;
            end
            if (load.bias_en) begin
                bias_q <= load.data;
            end
        end
    end

    assign weights = w_q;
    // Bias through the 32-bit view
    assign bias    = bias_q.word;

endmodule
